// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    // Address and data width of the RV32I core
    localparam int xlen = 32;

    // First fetch address out of reset
    localparam logic [xlen-1:0] reset_pc = '0;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operation codes seen in execute
    ////////////////////////////////////////////////////////////////////////////

    localparam int alu_op_width = 5;

    // Unconditional jumps
    localparam logic [alu_op_width-1:0] alu_jal  = 5'b01010;
    localparam logic [alu_op_width-1:0] alu_jalr = 5'b01011;

    // Conditional branches, one contiguous block of codes
    localparam logic [alu_op_width-1:0] alu_beq  = 5'b01100;
    localparam logic [alu_op_width-1:0] alu_bne  = 5'b01101;
    localparam logic [alu_op_width-1:0] alu_blt  = 5'b01110;
    localparam logic [alu_op_width-1:0] alu_bge  = 5'b01111;
    localparam logic [alu_op_width-1:0] alu_bltu = 5'b10000;
    localparam logic [alu_op_width-1:0] alu_bgeu = 5'b10001;

    ////////////////////////////////////////////////////////////////////////////
    // Branch target buffer sizing
    ////////////////////////////////////////////////////////////////////////////

    // 16 entries, direct mapped
    localparam int btb_index_bits = 4;
    localparam int btb_entries    = 2 ** btb_index_bits;

    // Whatever is left above index and byte offset
    localparam int btb_tag_bits = xlen - btb_index_bits - 2;

endpackage

`default_nettype wire

// ==== design/branch_target_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer
    import fetch_pkg::*;
(
    input  logic            CLK,
    input  logic            reset,

    // Lookup side follows the fetch PC
    input  logic [xlen-1:0] pc,
    output logic            predict_taken,
    output logic [xlen-1:0] predict_target,

    // Update side fed by branch resolution in execute
    input  logic            update,
    input  logic            update_taken,
    input  logic [xlen-1:0] update_pc,
    input  logic [xlen-1:0] update_target
);

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    logic [btb_entries-1:0]        valid;
    logic [btb_entries-1:0][1:0]   counter;
    logic [btb_tag_bits-1:0]       tags    [btb_entries];
    logic [xlen-1:0]               targets [btb_entries];

    logic [btb_index_bits-1:0]     lookup_index;
    logic [btb_tag_bits-1:0]       lookup_tag;
    logic [btb_index_bits-1:0]     update_index;
    logic [btb_tag_bits-1:0]       update_tag;
    logic                          update_hit;

    // Byte offset bits [1:0] are dropped
    assign lookup_index = pc[btb_index_bits+1:2];
    assign lookup_tag   = pc[xlen-1:btb_index_bits+2];
    assign update_index = update_pc[btb_index_bits+1:2];
    assign update_tag   = update_pc[xlen-1:btb_index_bits+2];

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////

    // Weakly or strongly taken means counter bit 1 set
    assign predict_taken  = valid[lookup_index]
                            && (tags[lookup_index] == lookup_tag)
                            && counter[lookup_index][1];
    assign predict_target = targets[lookup_index];

    ////////////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////////////

    assign update_hit = valid[update_index] && (tags[update_index] == update_tag);

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            valid   <= '0;
            counter <= '0;
        end
        else if (update)
        begin
            if (update_hit)
            begin
                // Saturating 2-bit counter
                if (update_taken && (counter[update_index] != 2'd3))
                    counter[update_index] <= counter[update_index] + 2'd1;
                else if (!update_taken && (counter[update_index] != 2'd0))
                    counter[update_index] <= counter[update_index] - 2'd1;
            end
            else if (update_taken)
            begin
                // New entry starts weakly taken
                valid[update_index]   <= 1'b1;
                counter[update_index] <= 2'd2;
            end
        end
    end

    // Tag and target only change on a taken outcome
    always_ff @(posedge CLK)
    begin
        if (update && update_taken)
        begin
            tags[update_index]    <= update_tag;
            targets[update_index] <= update_target;
        end
    end

    // A not-taken outcome never fills an empty slot
    a_not_taken_no_install : assert property (
        @(posedge CLK) disable iff (reset)
        (update && !update_taken && !update_hit) |=> (valid == $past(valid))
    );

endmodule

`default_nettype wire

// ==== design/branch_resolve.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_resolve
    import fetch_pkg::*;
(
    input  logic [alu_op_width-1:0] alu_instruction,
    input  logic                    branch_taken,
    input  logic [xlen-1:0]         pc_execution,
    input  logic [xlen-1:0]         rs1_data,
    input  logic [xlen-1:0]         imm,
    input  logic [xlen-1:0]         pc_decoding,

    output logic                    redirect,
    output logic [xlen-1:0]         redirect_pc,
    output logic                    clear_fetch,
    output logic                    clear_decode,
    output logic                    clear_execute,

    output logic                    btb_update,
    output logic                    btb_update_taken,
    output logic [xlen-1:0]         btb_update_pc,
    output logic [xlen-1:0]         btb_update_target
);

    logic            is_jal;
    logic            is_jalr;
    logic            is_branch;
    logic            is_control;
    logic            resolved_taken;
    logic [xlen-1:0] pc_rel_target;
    logic [xlen-1:0] jalr_target;
    logic [xlen-1:0] taken_target;
    logic [xlen-1:0] fall_through;
    logic [xlen-1:0] actual_next;

    ////////////////////////////////////////////////////////////////////////////
    // Decode of the execute-stage operation
    ////////////////////////////////////////////////////////////////////////////

    assign is_jal    = (alu_instruction == alu_jal);
    assign is_jalr   = (alu_instruction == alu_jalr);
    assign is_branch = (alu_instruction == alu_beq)  || (alu_instruction == alu_bne)
                    || (alu_instruction == alu_blt)  || (alu_instruction == alu_bge)
                    || (alu_instruction == alu_bltu) || (alu_instruction == alu_bgeu);

    assign is_control = is_jal || is_jalr || is_branch;

    // Jumps always count as taken
    assign resolved_taken = is_jal || is_jalr || (is_branch && branch_taken);

    ////////////////////////////////////////////////////////////////////////////
    // Candidate addresses
    ////////////////////////////////////////////////////////////////////////////

    // Two's complement add, signed imm wraps the same way
    assign pc_rel_target = $unsigned($signed(pc_execution) + $signed(imm));
    assign jalr_target   = $unsigned($signed(rs1_data) + $signed(imm)) & ~xlen'(1);
    assign taken_target  = is_jalr ? jalr_target : pc_rel_target;
    assign fall_through  = pc_execution + xlen'(4);

    assign actual_next = resolved_taken ? taken_target : fall_through;

    ////////////////////////////////////////////////////////////////////////////
    // Misprediction and flush
    ////////////////////////////////////////////////////////////////////////////

    // Decode holds whatever fetch guessed; compare against the real path
    assign redirect    = is_control && (actual_next != pc_decoding);
    assign redirect_pc = actual_next;

    assign clear_fetch   = redirect;
    assign clear_decode  = redirect;
    assign clear_execute = redirect;

    // Train the BTB on every resolved control instruction
    assign btb_update        = is_control;
    assign btb_update_taken  = resolved_taken;
    assign btb_update_pc     = pc_execution;
    assign btb_update_target = taken_target;

    // Decoder must never flag taken outside a control code
    always_comb
    begin
        a_taken_needs_control : assert final (branch_taken !== 1'b1 || is_control)
            else $error("branch_taken high with code %b", alu_instruction);
    end

endmodule

`default_nettype wire

// ==== design/program_counter_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_counter_stage
    import fetch_pkg::*;
(
    input  logic            CLK,
    input  logic            reset,
    input  logic            stall,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic [xlen-1:0] predict_target,
    input  logic            predict_taken,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pc_plus_4;

    assign pc_plus_4 = pc + xlen'(4);

    ////////////////////////////////////////////////////////////////////////////
    // PC register
    ////////////////////////////////////////////////////////////////////////////

    // Priority is redirect, stall, prediction, sequential
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            pc <= reset_pc;
        end
        else if (redirect)
        begin
            // Correction wins even over a stall
            pc <= redirect_pc;
        end
        else if (!stall)
        begin
            if (predict_taken)
                pc <= predict_target;
            else
                pc <= pc_plus_4;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_pc_aligned : assert property (
        @(posedge CLK) disable iff (reset)
        pc[1:0] == 2'b00
    );

    // Hold for one cycle when stalled and nothing to correct
    a_stall_holds : assert property (
        @(posedge CLK) disable iff (reset)
        (stall && !redirect) |=> (pc == $past(pc))
    );

endmodule

`default_nettype wire

// ==== design/fetch_front_end.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end
    import fetch_pkg::*;
(
    input  logic                    CLK,
    input  logic                    reset,
    input  logic                    stall,

    // Execute and decode stage state
    input  logic [alu_op_width-1:0] alu_instruction,
    input  logic                    branch_taken,
    input  logic [xlen-1:0]         pc_execution,
    input  logic [xlen-1:0]         rs1_data,
    input  logic [xlen-1:0]         imm,
    input  logic [xlen-1:0]         pc_decoding,

    output logic [xlen-1:0]         pc,
    output logic                    clear_fetch,
    output logic                    clear_decode,
    output logic                    clear_execute
);

    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    logic            predict_taken;
    logic [xlen-1:0] predict_target;
    logic            btb_update;
    logic            btb_update_taken;
    logic [xlen-1:0] btb_update_pc;
    logic [xlen-1:0] btb_update_target;

    program_counter_stage u_pc_stage (
        .CLK            (CLK),
        .reset          (reset),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .predict_target (predict_target),
        .predict_taken  (predict_taken),
        .pc             (pc)
    );

    // Lookup follows the live PC
    branch_target_buffer u_btb (
        .CLK            (CLK),
        .reset          (reset),
        .pc             (pc),
        .predict_taken  (predict_taken),
        .predict_target (predict_target),
        .update         (btb_update),
        .update_taken   (btb_update_taken),
        .update_pc      (btb_update_pc),
        .update_target  (btb_update_target)
    );

    branch_resolve u_resolve (
        .alu_instruction   (alu_instruction),
        .branch_taken      (branch_taken),
        .pc_execution      (pc_execution),
        .rs1_data          (rs1_data),
        .imm               (imm),
        .pc_decoding       (pc_decoding),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .clear_fetch       (clear_fetch),
        .clear_decode      (clear_decode),
        .clear_execute     (clear_execute),
        .btb_update        (btb_update),
        .btb_update_taken  (btb_update_taken),
        .btb_update_pc     (btb_update_pc),
        .btb_update_target (btb_update_target)
    );

endmodule

`default_nettype wire

// ==== verif/fetch_front_end_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_front_end_tb
    import fetch_pkg::*;
;

    // Directed run is under 100 cycles, leave ample margin
    localparam int cycle_limit = 400;

    logic                    CLK;
    logic                    reset;
    logic                    stall;
    logic [alu_op_width-1:0] alu_instruction;
    logic                    branch_taken;
    logic [xlen-1:0]         pc_execution;
    logic [xlen-1:0]         rs1_data;
    logic [xlen-1:0]         imm;
    logic [xlen-1:0]         pc_decoding;
    logic [xlen-1:0]         pc;
    logic                    clear_fetch;
    logic                    clear_decode;
    logic                    clear_execute;

    // Expected state, updated on the falling edge
    logic [xlen-1:0] exp_pc;
    logic            exp_flush;
    logic [xlen-1:0] model_pc;
    logic            pred_on;
    logic [xlen-1:0] pred_addr;
    logic [xlen-1:0] pred_target;

    int pc_errors;
    int flush_errors;
    int cycle_count;

    logic [alu_op_width-1:0] branch_codes [6];
    logic [xlen-1:0]         addr_a;
    logic [xlen-1:0]         addr_t;
    logic [xlen-1:0]         rs1_value;

    fetch_front_end DUT (
        .CLK             (CLK),
        .reset           (reset),
        .stall           (stall),
        .alu_instruction (alu_instruction),
        .branch_taken    (branch_taken),
        .pc_execution    (pc_execution),
        .rs1_data        (rs1_data),
        .imm             (imm),
        .pc_decoding     (pc_decoding),
        .pc              (pc),
        .clear_fetch     (clear_fetch),
        .clear_decode    (clear_decode),
        .clear_execute   (clear_execute)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(posedge CLK)
        cycle_count <= cycle_count + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_reset_pc : assert property (@(posedge CLK) $fell(reset) |-> pc == reset_pc)
        else
        begin
            pc_errors++;
            $display("ERR %0t: pc %h out of reset, expected %h", $time, $sampled(pc), reset_pc);
        end

    a_pc_tracks : assert property (@(posedge CLK) disable iff (reset) pc == exp_pc)
        else
        begin
            pc_errors++;
            $display("ERR %0t: pc %h, expected %h", $time, $sampled(pc), $sampled(exp_pc));
        end

    a_flush_level : assert property (
        @(posedge CLK) disable iff (reset)
        {clear_fetch, clear_decode, clear_execute} == {3{exp_flush}}
    )
        else
        begin
            flush_errors++;
            $display("ERR %0t: flushes %b%b%b, expected all %b", $time,
                     $sampled(clear_fetch), $sampled(clear_decode),
                     $sampled(clear_execute), $sampled(exp_flush));
        end

    ////////////////////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic is_control_code(input logic [alu_op_width-1:0] op);
        return op inside {alu_jal, alu_jalr, alu_beq, alu_bne, alu_blt, alu_bge,
                          alu_bltu, alu_bgeu};
    endfunction

    // Real successor of the execute-stage instruction
    function automatic logic [xlen-1:0] resolved_next(input logic [alu_op_width-1:0] op,
                                                      input logic taken,
                                                      input logic [xlen-1:0] pc_ex,
                                                      input logic [xlen-1:0] rs1,
                                                      input logic [xlen-1:0] im);
        logic [xlen-1:0] sum;
        sum = rs1 + im;
        case (op)
            alu_jal:  return pc_ex + im;
            alu_jalr: return {sum[xlen-1:1], 1'b0};
            default:  return taken ? pc_ex + im : pc_ex + 32'd4;
        endcase
    endfunction

    // Positive word offset, at least four instructions ahead
    function automatic logic [xlen-1:0] forward_offset();
        return 32'd16 + 32'd4 * ($urandom % 64);
    endfunction

    // Called on a falling edge, returns on the next one
    task automatic apply_cycle(input logic [alu_op_width-1:0] op, input logic taken,
                               input logic [xlen-1:0] pc_ex, input logic [xlen-1:0] rs1,
                               input logic [xlen-1:0] im, input logic [xlen-1:0] pc_dec,
                               input logic hold);
        logic [xlen-1:0] actual;
        logic            flush;
        actual = resolved_next(op, taken, pc_ex, rs1, im);
        flush  = is_control_code(op) && (actual != pc_dec);
        exp_pc          = model_pc;
        exp_flush       = flush;
        alu_instruction = op;
        branch_taken    = taken;
        pc_execution    = pc_ex;
        rs1_data        = rs1;
        imm             = im;
        pc_decoding     = pc_dec;
        stall           = hold;
        if (flush)
            model_pc = actual;
        else if (hold)
            model_pc = model_pc;
        else if (pred_on && (model_pc == pred_addr))
            model_pc = pred_target;
        else
            model_pc = model_pc + 32'd4;
        @(negedge CLK);
    endtask

    task automatic run_idle(input int cycles, input logic hold);
        repeat (cycles)
            apply_cycle('0, 1'b0, '0, '0, '0, '0, hold);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin : watchdog
        wait (cycle_count >= cycle_limit);
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        void'($urandom(21));
        branch_codes = '{alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu};
        reset           = 1'b1;
        stall           = 1'b0;
        alu_instruction = '0;
        branch_taken    = 1'b0;
        pc_execution    = '0;
        rs1_data        = '0;
        imm             = '0;
        pc_decoding     = '0;
        exp_pc          = reset_pc;
        exp_flush       = 1'b0;
        model_pc        = reset_pc;
        pred_on         = 1'b0;
        pred_addr       = '0;
        pred_target     = '0;
        pc_errors       = 0;
        flush_errors    = 0;
        cycle_count     = 0;

        repeat (8) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;

        // Sequential fetch, then stall and resume
        run_idle(6, 1'b0);
        run_idle(4, 1'b1);
        run_idle(3, 1'b0);

        // Wrong-path jumps and taken branches
        apply_cycle(alu_jal, 1'b0, model_pc - 8, '0, forward_offset(), model_pc - 4, 1'b0);
        run_idle(2, 1'b0);
        foreach (branch_codes[i])
        begin
            apply_cycle(branch_codes[i], 1'b1, model_pc - 8, '0, forward_offset(),
                        model_pc - 4, 1'b0);
            run_idle(1, 1'b0);
        end
        // rs1 odd so bit 0 clearing matters
        rs1_value = model_pc + forward_offset() + 32'd1;
        apply_cycle(alu_jalr, 1'b0, model_pc - 8, rs1_value, forward_offset(),
                    model_pc - 4, 1'b0);
        run_idle(2, 1'b1);
        apply_cycle(alu_jal, 1'b0, model_pc - 8, '0, forward_offset(), model_pc - 4, 1'b1);
        run_idle(2, 1'b0);

        // Correct path gives no flush
        imm = forward_offset();
        apply_cycle(alu_blt, 1'b1, model_pc - 8, '0, imm, model_pc - 8 + imm, 1'b0);
        apply_cycle(alu_bge, 1'b0, model_pc - 8, '0, forward_offset(), model_pc - 4, 1'b0);
        rs1_value = model_pc + 32'd201;
        apply_cycle(alu_jalr, 1'b0, model_pc - 8, rs1_value, 32'd8, model_pc + 32'd208,
                    1'b0);
        run_idle(2, 1'b0);

        ////////////////////////////////////////////////////////////////////////
        // Prediction and its reversal
        ////////////////////////////////////////////////////////////////////////

        addr_a = model_pc + 32'd40;
        addr_t = addr_a + 32'd64;
        apply_cycle(alu_bne, 1'b1, addr_a, '0, 32'd64, addr_t, 1'b0);
        pred_on     = 1'b1;
        pred_addr   = addr_a;
        pred_target = addr_t;
        while (model_pc != addr_a)
            run_idle(1, 1'b0);
        run_idle(1, 1'b0);

        // Counter drops below the taken threshold after this one
        apply_cycle(alu_bne, 1'b0, addr_a, '0, 32'd64, addr_t, 1'b0);
        pred_on = 1'b0;
        apply_cycle(alu_bne, 1'b0, addr_a, '0, 32'd64, addr_a + 32'd4, 1'b0);
        apply_cycle(alu_jal, 1'b0, addr_a - 16, '0, 32'd16, model_pc - 4, 1'b0);
        run_idle(3, 1'b0);

        $display("Errors: pc %0d, flush %0d, total %0d", pc_errors, flush_errors,
                 pc_errors + flush_errors);
        if (pc_errors + flush_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/fetch_pkg.sv
design/branch_target_buffer.sv
design/branch_resolve.sv
design/program_counter_stage.sv
design/fetch_front_end.sv
verif/fetch_front_end_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - design/fetch_pkg.sv
  - design/branch_target_buffer.sv
  - design/branch_resolve.sv
  - design/program_counter_stage.sv
  - design/fetch_front_end.sv
  - target: simulation
    files:
      - verif/fetch_front_end_tb.sv
